// File: rtl/eco_defs.svh
// ECO bus subsystem address map
// windows for RAM, timers and board I/O, plus timer register offsets
`ifndef ECO_DEFS_SVH
`define ECO_DEFS_SVH

// block RAM, one word per entry
`define ECO_RAM_BASE   32'h0000_0000
`define ECO_RAM_WORDS  4096
`define ECO_RAM_BYTES  (`ECO_RAM_WORDS * 4)

// interval timers, 16 bytes each
`define ECO_TMR0_BASE  32'h3000_0000
`define ECO_TMR1_BASE  32'h3000_0010
`define ECO_TMR_BYTES  16

// board I/O, LEDs and switches
`define ECO_BIO_BASE   32'h3010_0000
`define ECO_BIO_BYTES  8

// timer register word offsets
`define ECO_TMR_CTRL   0
`define ECO_TMR_DIV    1
`define ECO_TMR_CNT    2

`endif

// File: rtl/eco_pkg.sv
// ECO bus types
// master request, device request and device response, plus size encoding
package eco_pkg;

  // transfer size, data right-aligned on the bus
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // request from the bus master
  typedef struct packed {
    logic        en;
    logic        wr;
    size_e       size;
    logic [31:0] addr;
    logic [31:0] data;
  } bus_req_t;

  // request as seen by one device, offset relative to its window
  typedef struct packed {
    logic        en;
    logic        wr;
    size_e       size;
    logic [23:0] offset;
    logic [31:0] data;
  } dev_req_t;

  // read data zero-extended, wt holds off completion
  typedef struct packed {
    logic [31:0] data;
    logic        wt;
  } dev_rsp_t;

endpackage

// File: rtl/busctrl.sv
// ECO bus controller
// decodes the master address, routes the transfer to one device and
// returns that device's read data and wait level
`timescale 1ns/1ps
`include "eco_defs.svh"

module busctrl (
  // master side
  input  eco_pkg::bus_req_t bus_req,
  output eco_pkg::dev_rsp_t bus_rsp,
  // device requests
  output eco_pkg::dev_req_t ram_req,
  output eco_pkg::dev_req_t tmr0_req,
  output eco_pkg::dev_req_t tmr1_req,
  output eco_pkg::dev_req_t bio_req,
  // device responses
  input  eco_pkg::dev_rsp_t ram_rsp,
  input  eco_pkg::dev_rsp_t tmr0_rsp,
  input  eco_pkg::dev_rsp_t tmr1_rsp,
  input  eco_pkg::dev_rsp_t bio_rsp
);

  logic hit_ram;
  logic hit_tmr0;
  logic hit_tmr1;
  logic hit_bio;

  // unsigned distance from base, wraps below base to a large value
  function automatic logic in_win(
    input logic [31:0] addr,
    input logic [31:0] base,
    input logic [31:0] bytes
  );
    logic [31:0] rel;
    rel = addr - base;
    return rel < bytes;
  endfunction

  function automatic eco_pkg::dev_req_t route(
    input eco_pkg::bus_req_t req,
    input logic              hit,
    input logic [31:0]       base
  );
    eco_pkg::dev_req_t d;
    logic [31:0]       rel;
    rel      = req.addr - base;
    d.en     = req.en & hit;
    d.wr     = req.wr;
    d.size   = req.size;
    d.offset = rel[23:0];
    d.data   = req.data;
    return d;
  endfunction

  // address decode
  assign hit_ram  = in_win(bus_req.addr, `ECO_RAM_BASE, `ECO_RAM_BYTES);
  assign hit_tmr0 = in_win(bus_req.addr, `ECO_TMR0_BASE, `ECO_TMR_BYTES);
  assign hit_tmr1 = in_win(bus_req.addr, `ECO_TMR1_BASE, `ECO_TMR_BYTES);
  assign hit_bio  = in_win(bus_req.addr, `ECO_BIO_BASE, `ECO_BIO_BYTES);

  // requests, en only reaches the selected device
  assign ram_req  = route(bus_req, hit_ram, `ECO_RAM_BASE);
  assign tmr0_req = route(bus_req, hit_tmr0, `ECO_TMR0_BASE);
  assign tmr1_req = route(bus_req, hit_tmr1, `ECO_TMR1_BASE);
  assign bio_req  = route(bus_req, hit_bio, `ECO_BIO_BASE);

  // response select
  always_comb begin
    if (hit_ram) begin
      bus_rsp = ram_rsp;
    end else if (hit_tmr0) begin
      bus_rsp = tmr0_rsp;
    end else if (hit_tmr1) begin
      bus_rsp = tmr1_rsp;
    end else if (hit_bio) begin
      bus_rsp = bio_rsp;
    end else begin
      // unmapped, finishes at once with zero data
      bus_rsp.data = '0;
      bus_rsp.wt   = 1'b0;
    end
  end

endmodule

// File: rtl/ram.sv
// ECO block RAM
// one wait state per transfer, big-endian byte lanes, byte/half/word access
`timescale 1ns/1ps
`include "eco_defs.svh"

module ram (
  input  logic              clk,
  input  logic              rst_n,
  input  eco_pkg::dev_req_t req,
  output eco_pkg::dev_rsp_t rsp
);

  localparam int AW = $clog2(`ECO_RAM_WORDS);

  logic [31:0]   mem [`ECO_RAM_WORDS];
  logic          phase_q;
  logic [31:0]   rdata_q;
  logic [AW-1:0] idx;
  logic [1:0]    lane;
  logic [31:0]   rword;
  logic [3:0]    be;
  logic [31:0]   wdata;
  logic [31:0]   rext;

  assign idx   = req.offset[AW+1:2];
  assign lane  = req.offset[1:0];
  assign rword = mem[idx];

  // byte 0 sits in bits 31:24
  always_comb begin
    case (req.size)
      eco_pkg::SIZE_BYTE: begin
        be    = 4'b1000 >> lane;
        wdata = {4{req.data[7:0]}};
        rext  = 32'(rword[8*(3-lane) +: 8]);
      end
      eco_pkg::SIZE_HALF: begin
        be    = lane[1] ? 4'b0011 : 4'b1100;
        wdata = {2{req.data[15:0]}};
        rext  = 32'(lane[1] ? rword[15:0] : rword[31:16]);
      end
      default: begin
        be    = 4'b1111;
        wdata = req.data;
        rext  = rword;
      end
    endcase
  end

  // wait phase, back to zero after each completed transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase_q <= 1'b0;
    end else begin
      phase_q <= req.en & ~phase_q;
    end
  end

  // read lanes captured in the wait cycle, writes land on completion
  always_ff @(posedge clk) begin
    if (req.en && !phase_q) begin
      rdata_q <= rext;
    end
    if (req.en && phase_q && req.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  assign rsp.wt   = req.en & ~phase_q;
  assign rsp.data = rdata_q;

endmodule

// File: rtl/tmr.sv
// ECO interval timer
// divisor-loaded down-counter with expired flag and interrupt enable
`timescale 1ns/1ps
`include "eco_defs.svh"

module tmr (
  input  logic              clk,
  input  logic              rst_n,
  input  eco_pkg::dev_req_t req,
  output eco_pkg::dev_rsp_t rsp,
  output logic              irq
);

  logic [31:0] div_q;
  logic [31:0] cnt_q;
  logic        ien_q;
  logic        exp_q;
  logic        we;
  logic [1:0]  reg_sel;

  assign reg_sel = req.offset[3:2];
  // no wait states, every enabled write completes this cycle
  assign we      = req.en & req.wr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_q <= '0;
      cnt_q <= '0;
      ien_q <= 1'b0;
      exp_q <= 1'b0;
    end else begin
      if (we && reg_sel == `ECO_TMR_DIV) begin
        div_q <= req.data;
        cnt_q <= req.data;
      end else if (div_q != '0) begin
        // reload on the terminal count
        if (cnt_q == 32'd1) begin
          cnt_q <= div_q;
          exp_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 32'd1;
        end
      end
      // control write clears the flag, wins over a same-cycle expiry
      if (we && reg_sel == `ECO_TMR_CTRL) begin
        ien_q <= req.data[0];
        exp_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_sel)
      `ECO_TMR_CTRL: rsp.data = {30'b0, exp_q, ien_q};
      `ECO_TMR_DIV:  rsp.data = div_q;
      `ECO_TMR_CNT:  rsp.data = cnt_q;
      default:       rsp.data = '0;
    endcase
  end

  assign rsp.wt = 1'b0;
  assign irq    = exp_q & ien_q;

endmodule

// File: rtl/bio.sv
// ECO board I/O
// LED register and two-flop synchronized switch inputs
`timescale 1ns/1ps

module bio (
  input  logic              clk,
  input  logic              rst_n,
  input  eco_pkg::dev_req_t req,
  output eco_pkg::dev_rsp_t rsp,
  input  logic [3:0]        sw,
  output logic [7:0]        leds
);

  logic [7:0] leds_q;
  logic [3:0] sw_meta;
  logic [3:0] sw_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leds_q  <= '0;
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
      // word 0 only, switch word ignores writes
      if (req.en && req.wr && !req.offset[2]) begin
        leds_q <= req.data[7:0];
      end
    end
  end

  assign rsp.data = req.offset[2] ? {28'b0, sw_sync} : {24'b0, leds_q};
  assign rsp.wt   = 1'b0;
  assign leds     = leds_q;

endmodule

// File: rtl/eco_sys.sv
// ECO bus subsystem top level
// bus controller with RAM, two interval timers and board I/O,
// timer interrupts gathered into the 16-bit vector
`timescale 1ns/1ps

module eco_sys (
  input  logic              clk,
  input  logic              rst_n,
  input  eco_pkg::bus_req_t bus_req,
  output eco_pkg::dev_rsp_t bus_rsp,
  input  logic [3:0]        sw,
  output logic [7:0]        leds,
  output logic [15:0]       irq
);

  // device requests
  eco_pkg::dev_req_t ram_req;
  eco_pkg::dev_req_t tmr0_req;
  eco_pkg::dev_req_t tmr1_req;
  eco_pkg::dev_req_t bio_req;
  // device responses
  eco_pkg::dev_rsp_t ram_rsp;
  eco_pkg::dev_rsp_t tmr0_rsp;
  eco_pkg::dev_rsp_t tmr1_rsp;
  eco_pkg::dev_rsp_t bio_rsp;
  // interrupts
  logic              tmr0_irq;
  logic              tmr1_irq;

  busctrl busctrl1 (
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .ram_req  (ram_req),
    .tmr0_req (tmr0_req),
    .tmr1_req (tmr1_req),
    .bio_req  (bio_req),
    .ram_rsp  (ram_rsp),
    .tmr0_rsp (tmr0_rsp),
    .tmr1_rsp (tmr1_rsp),
    .bio_rsp  (bio_rsp)
  );

  ram ram1 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  tmr tmr1_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (tmr0_req),
    .rsp   (tmr0_rsp),
    .irq   (tmr0_irq)
  );

  tmr tmr1_1 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (tmr1_req),
    .rsp   (tmr1_rsp),
    .irq   (tmr1_irq)
  );

  bio bio1 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (bio_req),
    .rsp   (bio_rsp),
    .sw    (sw),
    .leds  (leds)
  );

  // timer 1 on bit 15, timer 0 on bit 14, the rest unused here
  assign irq = {tmr1_irq, tmr0_irq, 14'b0};

endmodule

// File: tb/tb_eco_sys.sv
// ECO bus subsystem testbench
// random bus traffic from a fixed seed checked against RAM, timer and board I/O models
`timescale 1ns/1ps
`include "eco_defs.svh"

module tb_eco_sys;

  localparam int SHADOW_WORDS = 64;
  localparam int XFER_TIMEOUT = 20;
  localparam int IRQ_TIMEOUT  = 80;
  localparam int SW_TIMEOUT   = 10;

  logic              clk;
  logic              rst_n;
  eco_pkg::bus_req_t bus_req;
  eco_pkg::dev_rsp_t bus_rsp;
  logic [3:0]        sw;
  logic [7:0]        leds;
  logic [15:0]       irq;

  // model state
  logic [31:0] shadow [SHADOW_WORDS];
  logic [3:0]  sw_model;
  int          errors;
  int          tests_run;
  int          tests_failed;

  eco_sys u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .sw      (sw),
    .leds    (leds),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err_before);
    end
  endtask

  // runs one transfer starting just after a rising edge
  task automatic bus_xfer(input logic wr, input logic [1:0] size, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int waits);
    logic        done;
    logic        wt_s;
    logic [31:0] data_s;
    done         = 1'b0;
    waits        = 0;
    rdata        = '0;
    bus_req.en   = 1'b1;
    bus_req.wr   = wr;
    bus_req.size = eco_pkg::size_e'(size);
    bus_req.addr = addr;
    bus_req.data = wdata;
    for (int cyc = 0; cyc < XFER_TIMEOUT && !done; cyc++) begin
      @(negedge clk);
      wt_s   = bus_rsp.wt;
      data_s = bus_rsp.data;
      @(posedge clk);
      if (!wt_s) begin
        done  = 1'b1;
        rdata = data_s;
      end else begin
        waits++;
      end
    end
    #1;
    bus_req.en = 1'b0;
    if (!done) begin
      $display("transfer to 0x%08h did not complete within %0d cycles", addr, XFER_TIMEOUT);
      errors++;
    end
  endtask

  // big-endian lane position of right-aligned data within a word
  function automatic int lane_shift(input logic [1:0] size, input logic [1:0] lane);
    case (size)
      2'd0:    return 8 * (3 - int'(lane));
      2'd1:    return (lane == 2'd0) ? 16 : 0;
      default: return 0;
    endcase
  endfunction

  function automatic logic [31:0] size_mask(input logic [1:0] size);
    case (size)
      2'd0:    return 32'h0000_00ff;
      2'd1:    return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic after_reset();
    logic [31:0] rd;
    int          waits;
    int          err_before;
    err_before = errors;
    check_value("irq", 32'(irq), 32'h0);
    check_value("leds", 32'(leds), 32'h0);
    check_value("bus_rsp.wt", 32'(bus_rsp.wt), 32'h0);
    bus_xfer(1'b0, 2'd2, `ECO_TMR0_BASE + 4 * `ECO_TMR_CTRL, '0, rd, waits);
    check_value("tmr0 ctrl", rd, 32'h0);
    bus_xfer(1'b0, 2'd2, `ECO_TMR1_BASE + 4 * `ECO_TMR_CTRL, '0, rd, waits);
    check_value("tmr1 ctrl", rd, 32'h0);
    finish_test("reset state", err_before);
  endtask

  task automatic ram_random_traffic();
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [1:0]  size;
    logic [1:0]  lane;
    logic        wr;
    int          word;
    int          sh;
    int          waits;
    int          err_before;
    err_before = errors;
    // fill with known contents from a pattern of the whole address
    for (int w = 0; w < SHADOW_WORDS; w++) begin
      addr      = `ECO_RAM_BASE + 32'(w) * 4;
      shadow[w] = (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[15:0]};
      bus_xfer(1'b1, 2'd2, addr, shadow[w], rd, waits);
    end
    for (int n = 0; n < 300; n++) begin
      word = $urandom_range(0, SHADOW_WORDS - 1);
      size = 2'($urandom_range(0, 2));
      if (size == 2'd0) begin
        lane = 2'($urandom_range(0, 3));
      end else if (size == 2'd1) begin
        lane = 2'($urandom_range(0, 1) * 2);
      end else begin
        lane = 2'd0;
      end
      wr    = 1'($urandom_range(0, 1));
      mask  = size_mask(size);
      sh    = lane_shift(size, lane);
      wdata = $urandom() & mask;
      addr  = `ECO_RAM_BASE + 32'(word) * 4 + 32'(lane);
      bus_xfer(wr, size, addr, wdata, rd, waits);
      check_value("ram wait cycles", 32'(waits), 32'h1);
      if (wr) begin
        shadow[word] = (shadow[word] & ~(mask << sh)) | (wdata << sh);
      end else begin
        check_value("ram read data", rd, (shadow[word] >> sh) & mask);
      end
    end
    finish_test("ram random", err_before);
  endtask

  task automatic unmapped_access();
    logic [31:0] holes [6];
    logic [31:0] rd;
    int          waits;
    int          err_before;
    err_before = errors;
    holes[0] = 32'h0000_4000;
    holes[1] = 32'h0001_0010;
    holes[2] = 32'h2000_0000;
    holes[3] = 32'h3000_0020;
    holes[4] = 32'h3010_0008;
    holes[5] = 32'hffff_fffc;
    foreach (holes[i]) begin
      bus_xfer(1'b1, 2'd2, holes[i], $urandom(), rd, waits);
      check_value("unmapped write wait cycles", 32'(waits), 32'h0);
      bus_xfer(1'b0, 2'd2, holes[i], '0, rd, waits);
      check_value("unmapped read wait cycles", 32'(waits), 32'h0);
      check_value("unmapped read data", rd, 32'h0);
    end
    // low address bits of the holes alias onto these words
    for (int w = 0; w < SHADOW_WORDS; w++) begin
      bus_xfer(1'b0, 2'd2, `ECO_RAM_BASE + 32'(w) * 4, '0, rd, waits);
      check_value("ram word after unmapped writes", rd, shadow[w]);
    end
    finish_test("unmapped access", err_before);
  endtask

  task automatic timer_interrupt(input int idx);
    logic [31:0] base;
    logic [31:0] rd;
    int          div;
    int          rise_at;
    int          bit_own;
    int          bit_other;
    int          waits;
    int          err_before;
    err_before = errors;
    base       = idx ? `ECO_TMR1_BASE : `ECO_TMR0_BASE;
    bit_own    = idx ? 15 : 14;
    bit_other  = idx ? 14 : 15;
    div        = $urandom_range(2, 40);
    rise_at    = 0;
    bus_xfer(1'b1, 2'd2, base + 4 * `ECO_TMR_CTRL, 32'h1, rd, waits);
    bus_xfer(1'b1, 2'd2, base + 4 * `ECO_TMR_DIV, 32'(div), rd, waits);
    check_value("irq right after divisor write", 32'(irq), 32'h0);
    for (int k = 1; k <= IRQ_TIMEOUT && rise_at == 0; k++) begin
      @(posedge clk);
      #1;
      check_value("irq other timer bit", 32'(irq[bit_other]), 32'h0);
      if (irq[bit_own]) begin
        rise_at = k;
      end
    end
    if (rise_at == 0) begin
      $display("timer %0d interrupt did not rise within %0d cycles", idx, IRQ_TIMEOUT);
      errors++;
    end else begin
      check_value("timer irq rise cycle", 32'(rise_at), 32'(div));
    end
    bus_xfer(1'b0, 2'd2, base + 4 * `ECO_TMR_CTRL, '0, rd, waits);
    check_value("timer ctrl with flag", rd, 32'h3);
    bus_xfer(1'b0, 2'd2, base + 4 * `ECO_TMR_DIV, '0, rd, waits);
    check_value("timer divisor", rd, 32'(div));
    // bit 1 written as one still clears the flag
    bus_xfer(1'b1, 2'd2, base + 4 * `ECO_TMR_CTRL, 32'h3, rd, waits);
    check_value("irq own bit after ctrl write", 32'(irq[bit_own]), 32'h0);
    // stop this timer so it stays quiet during the next test
    bus_xfer(1'b1, 2'd2, base + 4 * `ECO_TMR_CTRL, 32'h0, rd, waits);
    bus_xfer(1'b1, 2'd2, base + 4 * `ECO_TMR_DIV, 32'h0, rd, waits);
    check_value("irq after timer stop", 32'(irq), 32'h0);
    finish_test(idx ? "timer 1" : "timer 0", err_before);
  endtask

  task automatic board_io();
    logic [31:0] rd;
    logic [7:0]  led_val;
    logic [3:0]  new_sw;
    int          seen_at;
    int          waits;
    int          err_before;
    err_before = errors;
    for (int n = 0; n < 16; n++) begin
      led_val = 8'($urandom_range(0, 255));
      bus_xfer(1'b1, 2'd2, `ECO_BIO_BASE, {24'($urandom()), led_val}, rd, waits);
      check_value("leds", 32'(leds), 32'(led_val));
      bus_xfer(1'b0, 2'd2, `ECO_BIO_BASE, '0, rd, waits);
      check_value("led register", rd, 32'(led_val));
    end
    for (int n = 0; n < 8; n++) begin
      new_sw   = sw_model ^ 4'($urandom_range(1, 15));
      sw       = new_sw;
      sw_model = new_sw;
      seen_at  = 0;
      for (int k = 1; k <= SW_TIMEOUT && seen_at == 0; k++) begin
        bus_xfer(1'b0, 2'd2, `ECO_BIO_BASE + 4, '0, rd, waits);
        if (rd === {28'b0, new_sw}) begin
          seen_at = k;
        end
      end
      if (seen_at == 0) begin
        $display("switch value 0x%0h never reached the switch register", new_sw);
        errors++;
      end else begin
        // register updates on the second edge so the read ending on the third sees it
        check_value("switch sync delay", 32'(seen_at), 32'h3);
      end
    end
    finish_test("board io", err_before);
  endtask

  initial begin
    void'($urandom(32'h3a7d));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    sw_model     = 4'h0;
    rst_n        = 1'b0;
    bus_req      = '0;
    sw           = 4'h0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    after_reset();
    ram_random_traffic();
    unmapped_access();
    timer_interrupt(0);
    timer_interrupt(1);
    board_io();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+rtl
rtl/eco_pkg.sv
rtl/busctrl.sv
rtl/ram.sv
rtl/tmr.sv
rtl/bio.sv
rtl/eco_sys.sv
tb/tb_eco_sys.sv
